// File: vlog.f
rtl/riscv_pkg.sv
rtl/riscv_decode.sv
rtl/riscv_execute.sv
rtl/riscv_result.sv
rtl/riscv_tracer.sv
rtl/riscv_trace_core.sv
dv/riscv_trace_core_tb.sv

// File: Makefile
# Verilator build and run for the RV64 trace core.

VERILATOR ?= verilator
TOP       ?= riscv_trace_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= *** TEST PASSED ***

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so a failing run still shows its output.
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)." && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/riscv_trace_core_tb.sv
`timescale 1ns/1ps

module riscv_trace_core_tb;

  localparam int          INST_DEPTH     = 4;
  localparam logic [63:0] RESET_PC       = 64'h0000_0000_8000_0000;
  localparam int          DMEM_WORDS     = 32;
  localparam int          TRC_CREDITS    = 4;
  localparam int          NUM_ENTRIES    = 26;
  localparam int          TIMEOUT_FACTOR = 20;
  localparam int unsigned SEED           = 32'h12af_22ca;

  // RV64I encodings used to build the instruction words.
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LOAD   = 7'b0000011;
  localparam logic [2:0] F_ADD  = 3'b000;
  localparam logic [2:0] F_SLT  = 3'b010;
  localparam logic [2:0] F_D    = 3'b011;
  localparam logic [2:0] F_XOR  = 3'b100;
  localparam logic [2:0] F_OR   = 3'b110;
  localparam logic [2:0] F_AND  = 3'b111;

  logic        i_riscv_clk;
  logic        i_riscv_rst;
  logic        i_inst_valid;
  logic [31:0] i_inst;
  logic        o_inst_credit;
  logic        i_trc_credit;
  logic        o_trc_valid;
  logic [63:0] o_trc_pc;
  logic [31:0] o_trc_inst;
  logic [4:0]  o_trc_rdaddr;
  logic [63:0] o_trc_memaddr;
  logic [63:0] o_trc_store;
  logic [63:0] o_trc_rddata;

  // One row per instruction: the word and the trace fields it must produce.
  logic [31:0] tbl_inst  [NUM_ENTRIES];
  logic [4:0]  tbl_rd    [NUM_ENTRIES];
  logic [63:0] tbl_data  [NUM_ENTRIES];
  logic [63:0] tbl_addr  [NUM_ENTRIES];
  logic [63:0] tbl_store [NUM_ENTRIES];
  int          tbl_fill;

  int          errors;
  int          checks;
  int          sent;
  int          inst_returned;
  int          records;
  int          trc_returned;
  logic        trc_pending;
  int          trc_given;
  int          credit_wait;

  riscv_trace_core #(
    .INST_DEPTH  (INST_DEPTH),
    .RESET_PC    (RESET_PC),
    .DMEM_WORDS  (DMEM_WORDS),
    .TRC_CREDITS (TRC_CREDITS)
  ) dut_i (
    .i_riscv_clk   (i_riscv_clk),
    .i_riscv_rst   (i_riscv_rst),
    .i_inst_valid  (i_inst_valid),
    .i_inst        (i_inst),
    .o_inst_credit (o_inst_credit),
    .i_trc_credit  (i_trc_credit),
    .o_trc_valid   (o_trc_valid),
    .o_trc_pc      (o_trc_pc),
    .o_trc_inst    (o_trc_inst),
    .o_trc_rdaddr  (o_trc_rdaddr),
    .o_trc_memaddr (o_trc_memaddr),
    .o_trc_store   (o_trc_store),
    .o_trc_rddata  (o_trc_rddata)
  );

  always #5 i_riscv_clk = ~i_riscv_clk;

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("error: %s actual 0x%h expected 0x%h", name, actual, expected);
    end
  endtask

  // ****************************************
  // Instruction encoders.
  // ****************************************
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, F_D, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                           input logic [63:0] data, input logic [63:0] addr,
                           input logic [63:0] st);
    tbl_inst[tbl_fill]  = word;
    tbl_rd[tbl_fill]    = rd;
    tbl_data[tbl_fill]  = data;
    tbl_addr[tbl_fill]  = addr;
    tbl_store[tbl_fill] = st;
    tbl_fill++;
  endtask

  task automatic fill_table();
    add_entry(enc_i(12'h005, 5'd0, F_ADD, 5'd1, OP_IMM), 5'd1, 64'd5, 64'd0, 64'd0);
    add_entry(enc_i(12'hffd, 5'd0, F_ADD, 5'd2, OP_IMM), 5'd2, 64'hffff_ffff_ffff_fffd,
              64'd0, 64'd0);
    add_entry(enc_r(7'h00, 5'd2, 5'd1, F_ADD, 5'd3), 5'd3, 64'd2, 64'd0, 64'd0);
    add_entry(enc_r(7'h20, 5'd2, 5'd1, F_ADD, 5'd4), 5'd4, 64'd8, 64'd0, 64'd0);
    add_entry(enc_r(7'h00, 5'd1, 5'd2, F_SLT, 5'd5), 5'd5, 64'd1, 64'd0, 64'd0);
    add_entry(enc_r(7'h00, 5'd2, 5'd1, F_SLT, 5'd6), 5'd6, 64'd0, 64'd0, 64'd0);
    add_entry(enc_u(20'h12345, 5'd7), 5'd7, 64'h1234_5000, 64'd0, 64'd0);
    add_entry(enc_u(20'h80000, 5'd8), 5'd8, 64'hffff_ffff_8000_0000, 64'd0, 64'd0);
    add_entry(enc_i(12'h0f0, 5'd7, F_XOR, 5'd9, OP_IMM), 5'd9, 64'h1234_50f0, 64'd0, 64'd0);
    add_entry(enc_i(12'h00f, 5'd9, F_OR, 5'd10, OP_IMM), 5'd10, 64'h1234_50ff, 64'd0, 64'd0);
    add_entry(enc_i(12'h0ff, 5'd10, F_AND, 5'd11, OP_IMM), 5'd11, 64'hff, 64'd0, 64'd0);
    add_entry(enc_r(7'h00, 5'd8, 5'd7, F_OR, 5'd12), 5'd12, 64'hffff_ffff_9234_5000,
              64'd0, 64'd0);
    add_entry(enc_r(7'h00, 5'd2, 5'd12, F_XOR, 5'd13), 5'd13, 64'h6dcb_affd, 64'd0, 64'd0);
    add_entry(enc_i(12'h007, 5'd1, F_ADD, 5'd0, OP_IMM), 5'd0, 64'd0, 64'd0, 64'd0);
    add_entry(enc_r(7'h00, 5'd1, 5'd0, F_ADD, 5'd14), 5'd14, 64'd5, 64'd0, 64'd0);
    add_entry(enc_i(12'h040, 5'd0, F_ADD, 5'd15, OP_IMM), 5'd15, 64'h40, 64'd0, 64'd0);
    add_entry(enc_s(12'h008, 5'd13, 5'd15), 5'd0, 64'd0, 64'h48, 64'h6dcb_affd);
    add_entry(enc_i(12'h008, 5'd15, F_D, 5'd16, LOAD), 5'd16, 64'h6dcb_affd, 64'h48, 64'd0);
    add_entry(enc_r(7'h00, 5'd16, 5'd16, F_ADD, 5'd17), 5'd17, 64'hdb97_5ffa, 64'd0, 64'd0);
    add_entry(enc_s(12'hff8, 5'd12, 5'd15), 5'd0, 64'd0, 64'h38, 64'hffff_ffff_9234_5000);
    add_entry(32'hffff_ffff, 5'd0, 64'd0, 64'd0, 64'd0); // Unknown opcode.
    add_entry(enc_i(12'h038, 5'd0, F_D, 5'd18, LOAD), 5'd18, 64'hffff_ffff_9234_5000,
              64'h38, 64'd0);
    add_entry(enc_r(7'h20, 5'd17, 5'd18, F_ADD, 5'd19), 5'd19, 64'hffff_fffe_b69c_f006,
              64'd0, 64'd0);
    add_entry(enc_r(7'h00, 5'd0, 5'd19, F_SLT, 5'd20), 5'd20, 64'd1, 64'd0, 64'd0);
    add_entry(enc_r(7'h00, 5'd17, 5'd19, F_AND, 5'd21), 5'd21, 64'h9294_5002, 64'd0, 64'd0);
    add_entry(enc_r(7'h01, 5'd2, 5'd1, F_ADD, 5'd21), 5'd0, 64'd0, 64'd0, 64'd0);
  endtask

  task automatic check_idle();
    check_value("o_trc_valid", 64'(o_trc_valid), 64'd0);
    check_value("o_inst_credit", 64'(o_inst_credit), 64'd0);
    check_value("o_trc_pc", o_trc_pc, 64'd0);
    check_value("o_trc_inst", 64'(o_trc_inst), 64'd0);
    check_value("o_trc_rdaddr", 64'(o_trc_rdaddr), 64'd0);
    check_value("o_trc_rddata", o_trc_rddata, 64'd0);
    check_value("o_trc_memaddr", o_trc_memaddr, 64'd0);
    check_value("o_trc_store", o_trc_store, 64'd0);
  endtask

  task automatic compare_record(input int idx);
    check_value("o_trc_pc", o_trc_pc, RESET_PC + 64'(4 * idx));
    check_value("o_trc_inst", 64'(o_trc_inst), 64'(tbl_inst[idx]));
    check_value("o_trc_rdaddr", 64'(o_trc_rdaddr), 64'(tbl_rd[idx]));
    check_value("o_trc_rddata", o_trc_rddata, tbl_data[idx]);
    check_value("o_trc_memaddr", o_trc_memaddr, tbl_addr[idx]);
    check_value("o_trc_store", o_trc_store, tbl_store[idx]);
  endtask

  // ****************************************
  // Monitor, sampled mid-cycle.
  // ****************************************
  always @(negedge i_riscv_clk)
  begin
    if (o_inst_credit)
    begin
      inst_returned++;
      if (inst_returned > sent)
      begin
        errors++;
        $display("instruction credit returned with no instruction outstanding");
      end
    end
    if (o_trc_valid)
    begin
      if (records >= NUM_ENTRIES)
      begin
        errors++;
        $display("unexpected trace record after the last instruction, pc 0x%h", o_trc_pc);
      end
      else
      begin
        if (TRC_CREDITS - records + trc_returned <= 0)
        begin
          errors++;
          $display("trace record %0d was sent without a trace credit", records);
        end
        compare_record(records);
      end
      records++;
    end
    // A credit seen here is sampled at the next edge and can be spent one edge later.
    if (trc_pending)
      trc_returned++;
    trc_pending = i_trc_credit;
  end

  // Trace consumer frees each record after 0 to 3 cycles.
  initial
  begin
    @(negedge i_riscv_rst);
    credit_wait = int'($urandom % 4);
    forever
    begin
      @(posedge i_riscv_clk);
      #1;
      i_trc_credit = 1'b0;
      if (records > trc_given)
      begin
        if (credit_wait == 0)
        begin
          i_trc_credit = 1'b1;
          trc_given++;
          credit_wait = int'($urandom % 4);
        end
        else
          credit_wait--;
      end
    end
  end

  initial
  begin
    repeat (TIMEOUT_FACTOR * NUM_ENTRIES) @(posedge i_riscv_clk);
    $display("timeout: %0d of %0d trace records seen after %0d cycles", records,
             NUM_ENTRIES, TIMEOUT_FACTOR * NUM_ENTRIES);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ****************************************
  // Main sequence.
  // ****************************************
  initial
  begin
    void'($urandom(SEED));
    i_riscv_clk   = 1'b0;
    i_riscv_rst   = 1'b1;
    i_inst_valid  = 1'b0;
    i_inst        = '0;
    i_trc_credit  = 1'b0;
    trc_pending   = 1'b0;
    errors        = 0;
    checks        = 0;
    sent          = 0;
    inst_returned = 0;
    records       = 0;
    trc_returned  = 0;
    trc_given     = 0;
    tbl_fill      = 0;
    fill_table();
    check_value("table entries", 64'(tbl_fill), 64'(NUM_ENTRIES));

    repeat (5) @(posedge i_riscv_clk);
    #1;
    i_riscv_rst = 1'b0;
    repeat (3)
    begin
      @(negedge i_riscv_clk);
      check_idle();
    end

    // Send only while holding an instruction credit.
    while (sent < NUM_ENTRIES)
    begin
      @(posedge i_riscv_clk);
      #1;
      if (INST_DEPTH - sent + inst_returned > 0)
      begin
        i_inst_valid = 1'b1;
        i_inst       = tbl_inst[sent];
        sent++;
      end
      else
      begin
        i_inst_valid = 1'b0;
        i_inst       = '0;
      end
    end
    @(posedge i_riscv_clk);
    #1;
    i_inst_valid = 1'b0;
    i_inst       = '0;

    wait (records == NUM_ENTRIES);
    repeat (10) @(negedge i_riscv_clk);
    check_value("instruction credits returned", 64'(inst_returned), 64'(NUM_ENTRIES));

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: rtl/riscv_trace_core.sv
`timescale 1ns/1ps

module riscv_trace_core
  import riscv_pkg::*;
#(
  parameter int              INST_DEPTH  = 4,
  parameter logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_8000_0000,
  parameter int              DMEM_WORDS  = 32,
  parameter int              TRC_CREDITS = 4
) (
  input  logic               i_riscv_clk,
  input  logic               i_riscv_rst,
  input  logic               i_inst_valid,
  input  logic [ILEN-1:0]    i_inst,
  output logic               o_inst_credit,
  input  logic               i_trc_credit,
  output logic               o_trc_valid,
  output logic [XLEN-1:0]    o_trc_pc,
  output logic [ILEN-1:0]    o_trc_inst,
  output logic [RADDR_W-1:0] o_trc_rdaddr,
  output logic [XLEN-1:0]    o_trc_memaddr,
  output logic [XLEN-1:0]    o_trc_store,
  output logic [XLEN-1:0]    o_trc_rddata
);

  logic               stall;
  logic               wb_we;
  logic [RADDR_W-1:0] wb_rd;
  logic [XLEN-1:0]    wb_data;

  // Decode to execute.
  logic               dec_valid;
  logic [XLEN-1:0]    dec_pc;
  logic [ILEN-1:0]    dec_inst;
  logic [RADDR_W-1:0] dec_rd;
  logic [RADDR_W-1:0] dec_rs1;
  logic [RADDR_W-1:0] dec_rs2;
  logic [XLEN-1:0]    dec_op_a;
  logic [XLEN-1:0]    dec_op_b;
  logic [XLEN-1:0]    dec_imm;
  logic [2:0]         dec_alu_op;
  logic               dec_we;
  logic               dec_load;
  logic               dec_store;

  // Execute to result.
  logic               exe_valid;
  logic [XLEN-1:0]    exe_pc;
  logic [ILEN-1:0]    exe_inst;
  logic [RADDR_W-1:0] exe_rd;
  logic [XLEN-1:0]    exe_result;
  logic [XLEN-1:0]    exe_store_data;
  logic               exe_we;
  logic               exe_load;
  logic               exe_store;

  // Result to tracer.
  logic               retire;
  logic [XLEN-1:0]    ret_pc;
  logic [ILEN-1:0]    ret_inst;
  logic [RADDR_W-1:0] ret_rd;
  logic [XLEN-1:0]    ret_memaddr;
  logic [XLEN-1:0]    ret_store;
  logic [XLEN-1:0]    ret_rddata;

  riscv_decode #(
    .INST_DEPTH (INST_DEPTH),
    .RESET_PC   (RESET_PC)
  ) decode_i (
    .i_riscv_clk   (i_riscv_clk),
    .i_riscv_rst   (i_riscv_rst),
    .i_inst_valid  (i_inst_valid),
    .i_inst        (i_inst),
    .o_inst_credit (o_inst_credit),
    .i_stall       (stall),
    .i_wb_we       (wb_we),
    .i_wb_rd       (wb_rd),
    .i_wb_data     (wb_data),
    .o_dec_valid   (dec_valid),
    .o_dec_pc      (dec_pc),
    .o_dec_inst    (dec_inst),
    .o_dec_rd      (dec_rd),
    .o_dec_rs1     (dec_rs1),
    .o_dec_rs2     (dec_rs2),
    .o_dec_op_a    (dec_op_a),
    .o_dec_op_b    (dec_op_b),
    .o_dec_imm     (dec_imm),
    .o_dec_alu_op  (dec_alu_op),
    .o_dec_we      (dec_we),
    .o_dec_load    (dec_load),
    .o_dec_store   (dec_store)
  );

  riscv_execute execute_i (
    .i_riscv_clk      (i_riscv_clk),
    .i_riscv_rst      (i_riscv_rst),
    .i_stall          (stall),
    .i_dec_valid      (dec_valid),
    .i_dec_pc         (dec_pc),
    .i_dec_inst       (dec_inst),
    .i_dec_rd         (dec_rd),
    .i_dec_rs1        (dec_rs1),
    .i_dec_rs2        (dec_rs2),
    .i_dec_op_a       (dec_op_a),
    .i_dec_op_b       (dec_op_b),
    .i_dec_imm        (dec_imm),
    .i_dec_alu_op     (dec_alu_op),
    .i_dec_we         (dec_we),
    .i_dec_load       (dec_load),
    .i_dec_store      (dec_store),
    .i_wb_we          (wb_we),
    .i_wb_rd          (wb_rd),
    .i_wb_data        (wb_data),
    .o_exe_valid      (exe_valid),
    .o_exe_pc         (exe_pc),
    .o_exe_inst       (exe_inst),
    .o_exe_rd         (exe_rd),
    .o_exe_result     (exe_result),
    .o_exe_store_data (exe_store_data),
    .o_exe_we         (exe_we),
    .o_exe_load       (exe_load),
    .o_exe_store      (exe_store)
  );

  riscv_result #(
    .DMEM_WORDS (DMEM_WORDS)
  ) result_i (
    .i_riscv_clk      (i_riscv_clk),
    .i_riscv_rst      (i_riscv_rst),
    .i_stall          (stall),
    .i_exe_valid      (exe_valid),
    .i_exe_pc         (exe_pc),
    .i_exe_inst       (exe_inst),
    .i_exe_rd         (exe_rd),
    .i_exe_result     (exe_result),
    .i_exe_store_data (exe_store_data),
    .i_exe_we         (exe_we),
    .i_exe_load       (exe_load),
    .i_exe_store      (exe_store),
    .o_wb_we          (wb_we),
    .o_wb_rd          (wb_rd),
    .o_wb_data        (wb_data),
    .o_retire         (retire),
    .o_ret_pc         (ret_pc),
    .o_ret_inst       (ret_inst),
    .o_ret_rd         (ret_rd),
    .o_ret_memaddr    (ret_memaddr),
    .o_ret_store      (ret_store),
    .o_ret_rddata     (ret_rddata)
  );

  riscv_tracer #(
    .TRC_CREDITS (TRC_CREDITS)
  ) tracer_i (
    .i_riscv_clk   (i_riscv_clk),
    .i_riscv_rst   (i_riscv_rst),
    .i_retire      (retire),
    .i_trc_pc      (ret_pc),
    .i_trc_inst    (ret_inst),
    .i_trc_rdaddr  (ret_rd),
    .i_trc_memaddr (ret_memaddr),
    .i_trc_store   (ret_store),
    .i_trc_rddata  (ret_rddata),
    .i_trc_credit  (i_trc_credit),
    .o_stall       (stall),
    .o_trc_valid   (o_trc_valid),
    .o_trc_pc      (o_trc_pc),
    .o_trc_inst    (o_trc_inst),
    .o_trc_rdaddr  (o_trc_rdaddr),
    .o_trc_memaddr (o_trc_memaddr),
    .o_trc_store   (o_trc_store),
    .o_trc_rddata  (o_trc_rddata)
  );

endmodule

// File: rtl/riscv_tracer.sv
`timescale 1ns/1ps

module riscv_tracer
  import riscv_pkg::*;
#(
  parameter int TRC_CREDITS = 4
) (
  input  logic               i_riscv_clk,
  input  logic               i_riscv_rst,
  input  logic               i_retire,
  input  logic [XLEN-1:0]    i_trc_pc,
  input  logic [ILEN-1:0]    i_trc_inst,
  input  logic [RADDR_W-1:0] i_trc_rdaddr,
  input  logic [XLEN-1:0]    i_trc_memaddr,
  input  logic [XLEN-1:0]    i_trc_store,
  input  logic [XLEN-1:0]    i_trc_rddata,
  input  logic               i_trc_credit,
  output logic               o_stall,
  output logic               o_trc_valid,
  output logic [XLEN-1:0]    o_trc_pc,
  output logic [ILEN-1:0]    o_trc_inst,
  output logic [RADDR_W-1:0] o_trc_rdaddr,
  output logic [XLEN-1:0]    o_trc_memaddr,
  output logic [XLEN-1:0]    o_trc_store,
  output logic [XLEN-1:0]    o_trc_rddata
);

  localparam int CW = $clog2(TRC_CREDITS + 1);

  logic [CW-1:0] credits;
  logic          accept;

  assign accept  = i_retire && (credits != '0);
  assign o_stall = i_retire && (credits == '0); // Holds every stage until a credit returns.

  always_ff @(posedge i_riscv_clk or posedge i_riscv_rst)
  begin
    if (i_riscv_rst)
    begin
      credits       <= CW'(TRC_CREDITS);
      o_trc_valid   <= 1'b0;
      o_trc_pc      <= '0;
      o_trc_inst    <= '0;
      o_trc_rdaddr  <= '0;
      o_trc_memaddr <= '0;
      o_trc_store   <= '0;
      o_trc_rddata  <= '0;
    end
    else
    begin
      credits     <= credits + CW'(i_trc_credit) - CW'(accept);
      o_trc_valid <= accept;
      if (accept)
      begin
        o_trc_pc      <= i_trc_pc;
        o_trc_inst    <= i_trc_inst;
        o_trc_rdaddr  <= i_trc_rdaddr;
        o_trc_memaddr <= i_trc_memaddr;
        o_trc_store   <= i_trc_store;
        o_trc_rddata  <= i_trc_rddata;
      end
    end
  end

  // The consumer can only return credits for records it has been sent.
  a_credit_max: assert property (@(posedge i_riscv_clk) disable iff (i_riscv_rst)
    credits <= CW'(TRC_CREDITS));

endmodule

// File: rtl/riscv_result.sv
`timescale 1ns/1ps

module riscv_result
  import riscv_pkg::*;
#(
  parameter int DMEM_WORDS = 32
) (
  input  logic               i_riscv_clk,
  input  logic               i_riscv_rst,
  input  logic               i_stall,
  input  logic               i_exe_valid,
  input  logic [XLEN-1:0]    i_exe_pc,
  input  logic [ILEN-1:0]    i_exe_inst,
  input  logic [RADDR_W-1:0] i_exe_rd,
  input  logic [XLEN-1:0]    i_exe_result,
  input  logic [XLEN-1:0]    i_exe_store_data,
  input  logic               i_exe_we,
  input  logic               i_exe_load,
  input  logic               i_exe_store,
  output logic               o_wb_we,
  output logic [RADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]    o_wb_data,
  output logic               o_retire,
  output logic [XLEN-1:0]    o_ret_pc,
  output logic [ILEN-1:0]    o_ret_inst,
  output logic [RADDR_W-1:0] o_ret_rd,
  output logic [XLEN-1:0]    o_ret_memaddr,
  output logic [XLEN-1:0]    o_ret_store,
  output logic [XLEN-1:0]    o_ret_rddata
);

  localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

  logic [XLEN-1:0]  dmem [DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic             mem_wr;
  logic [XLEN-1:0]  rd_value;

  // Doubleword index; upper address bits wrap around the memory.
  assign idx    = i_exe_result[3 +: IDX_W];
  assign mem_wr = i_exe_valid && i_exe_store && !i_stall;

  // ****************************************
  // Data memory.
  // ****************************************
  always_ff @(posedge i_riscv_clk or posedge i_riscv_rst)
  begin
    if (i_riscv_rst)
    begin
      for (int k = 0; k < DMEM_WORDS; k++)
        dmem[k] <= '0;
    end
    else if (mem_wr)
      dmem[idx] <= i_exe_store_data;
  end

  assign rd_value = i_exe_load ? dmem[idx] : i_exe_result; // Loads read in this cycle.

  // ****************************************
  // Write-back and retire.
  // ****************************************
  assign o_wb_we   = i_exe_valid && i_exe_we && !i_stall;
  assign o_wb_rd   = i_exe_rd;
  assign o_wb_data = rd_value;

  assign o_retire      = i_exe_valid;
  assign o_ret_pc      = i_exe_pc;
  assign o_ret_inst    = i_exe_inst;
  assign o_ret_rd      = i_exe_we ? i_exe_rd : '0;
  assign o_ret_rddata  = i_exe_we ? rd_value : '0;
  assign o_ret_memaddr = (i_exe_load || i_exe_store) ? i_exe_result : '0;
  assign o_ret_store   = i_exe_store ? i_exe_store_data : '0;

  // Only doubleword accesses exist, so every address must be 8-byte aligned.
  a_aligned: assert property (@(posedge i_riscv_clk) disable iff (i_riscv_rst)
    i_exe_valid && (i_exe_load || i_exe_store) |-> i_exe_result[2:0] == 3'b000);

endmodule

// File: rtl/riscv_execute.sv
`timescale 1ns/1ps

module riscv_execute
  import riscv_pkg::*;
(
  input  logic               i_riscv_clk,
  input  logic               i_riscv_rst,
  input  logic               i_stall,
  input  logic               i_dec_valid,
  input  logic [XLEN-1:0]    i_dec_pc,
  input  logic [ILEN-1:0]    i_dec_inst,
  input  logic [RADDR_W-1:0] i_dec_rd,
  input  logic [RADDR_W-1:0] i_dec_rs1,
  input  logic [RADDR_W-1:0] i_dec_rs2,
  input  logic [XLEN-1:0]    i_dec_op_a,
  input  logic [XLEN-1:0]    i_dec_op_b,
  input  logic [XLEN-1:0]    i_dec_imm,
  input  logic [2:0]         i_dec_alu_op,
  input  logic               i_dec_we,
  input  logic               i_dec_load,
  input  logic               i_dec_store,
  input  logic               i_wb_we,
  input  logic [RADDR_W-1:0] i_wb_rd,
  input  logic [XLEN-1:0]    i_wb_data,
  output logic               o_exe_valid,
  output logic [XLEN-1:0]    o_exe_pc,
  output logic [ILEN-1:0]    o_exe_inst,
  output logic [RADDR_W-1:0] o_exe_rd,
  output logic [XLEN-1:0]    o_exe_result,
  output logic [XLEN-1:0]    o_exe_store_data,
  output logic               o_exe_we,
  output logic               o_exe_load,
  output logic               o_exe_store
);

  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_out;

  // The instruction one ahead is in the result stage; take its value if it matches.
  assign src_a = (i_wb_we && i_wb_rd == i_dec_rs1 && i_dec_rs1 != '0) ?
                 i_wb_data : i_dec_op_a;
  assign src_b = (i_wb_we && i_wb_rd == i_dec_rs2 && i_dec_rs2 != '0) ?
                 i_wb_data : i_dec_op_b;

  // Only register-register operations use rs2 as the second ALU input.
  assign alu_b = (i_dec_inst[6:0] == OPC_OP) ? src_b : i_dec_imm;

  always_comb
  begin
    case (i_dec_alu_op)
      ALU_SUB:   alu_out = src_a - alu_b;
      ALU_AND:   alu_out = src_a & alu_b;
      ALU_OR:    alu_out = src_a | alu_b;
      ALU_XOR:   alu_out = src_a ^ alu_b;
      ALU_SLT:   alu_out = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(alu_b)};
      ALU_PASSB: alu_out = alu_b;
      default:   alu_out = src_a + alu_b; // Also the load and store address.
    endcase
  end

  always_ff @(posedge i_riscv_clk or posedge i_riscv_rst)
  begin
    if (i_riscv_rst)
    begin
      o_exe_valid <= 1'b0;
      o_exe_we    <= 1'b0;
      o_exe_load  <= 1'b0;
      o_exe_store <= 1'b0;
    end
    else if (!i_stall)
    begin
      o_exe_valid <= i_dec_valid;
      o_exe_we    <= i_dec_we;
      o_exe_load  <= i_dec_load;
      o_exe_store <= i_dec_store;
    end
  end

  always_ff @(posedge i_riscv_clk)
  begin
    if (!i_stall)
    begin
      o_exe_pc         <= i_dec_pc;
      o_exe_inst       <= i_dec_inst;
      o_exe_rd         <= i_dec_rd;
      o_exe_result     <= alu_out;
      o_exe_store_data <= src_b;
    end
  end

endmodule

// File: rtl/riscv_decode.sv
`timescale 1ns/1ps

module riscv_decode
  import riscv_pkg::*;
#(
  parameter int              INST_DEPTH = 4,
  parameter logic [XLEN-1:0] RESET_PC   = 64'h0000_0000_8000_0000
) (
  input  logic               i_riscv_clk,
  input  logic               i_riscv_rst,
  input  logic               i_inst_valid,
  input  logic [ILEN-1:0]    i_inst,
  output logic               o_inst_credit,
  input  logic               i_stall,
  input  logic               i_wb_we,
  input  logic [RADDR_W-1:0] i_wb_rd,
  input  logic [XLEN-1:0]    i_wb_data,
  output logic               o_dec_valid,
  output logic [XLEN-1:0]    o_dec_pc,
  output logic [ILEN-1:0]    o_dec_inst,
  output logic [RADDR_W-1:0] o_dec_rd,
  output logic [RADDR_W-1:0] o_dec_rs1,
  output logic [RADDR_W-1:0] o_dec_rs2,
  output logic [XLEN-1:0]    o_dec_op_a,
  output logic [XLEN-1:0]    o_dec_op_b,
  output logic [XLEN-1:0]    o_dec_imm,
  output logic [2:0]         o_dec_alu_op,
  output logic               o_dec_we,
  output logic               o_dec_load,
  output logic               o_dec_store
);

  localparam int PTR_W = (INST_DEPTH > 1) ? $clog2(INST_DEPTH) : 1;
  localparam int CNT_W = $clog2(INST_DEPTH + 1);

  logic [ILEN-1:0]    q_mem [INST_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   q_count;
  logic               issue;
  logic [XLEN-1:0]    pc;
  logic [XLEN-1:0]    regs [1:31];
  riscv_inst_u        head;
  logic [RADDR_W-1:0] rd;
  logic [RADDR_W-1:0] rs1;
  logic [RADDR_W-1:0] rs2;
  logic [XLEN-1:0]    imm;
  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_b;
  logic [2:0]         alu_op;
  logic               legal;
  logic               wr_ok;
  logic               load;
  logic               store;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(INST_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign issue         = (q_count != '0) && !i_stall;
  assign o_inst_credit = issue; // One credit back per entry leaving the queue.
  assign head          = q_mem[rd_ptr];

  // ****************************************
  // Instruction queue.
  // ****************************************
  always_ff @(posedge i_riscv_clk or posedge i_riscv_rst)
  begin
    if (i_riscv_rst)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end
    else
    begin
      if (i_inst_valid)
        wr_ptr <= next_ptr(wr_ptr);
      if (issue)
        rd_ptr <= next_ptr(rd_ptr);
      q_count <= q_count + CNT_W'(i_inst_valid) - CNT_W'(issue);
    end
  end

  always_ff @(posedge i_riscv_clk)
  begin
    if (i_inst_valid)
      q_mem[wr_ptr] <= i_inst; // Arrivals are taken even under stall.
    if (i_wb_we && i_wb_rd != '0)
      regs[i_wb_rd] <= i_wb_data;
  end

  // Register read, with a write in the same cycle passed straight through.
  assign op_a = (rs1 == '0) ? '0 :
                (i_wb_we && i_wb_rd == rs1) ? i_wb_data : regs[rs1];
  assign op_b = (rs2 == '0) ? '0 :
                (i_wb_we && i_wb_rd == rs2) ? i_wb_data : regs[rs2];

  // ****************************************
  // Decode of the queue head.
  // ****************************************
  always_comb
  begin
    rd     = '0;
    rs1    = '0;
    rs2    = '0;
    imm    = '0;
    alu_op = ALU_ADD;
    legal  = 1'b1;
    wr_ok  = 1'b0;
    load   = 1'b0;
    store  = 1'b0;
    case (head.r.opcode)
      OPC_OP:
      begin
        rd  = head.r.rd;
        rs1 = head.r.rs1;
        rs2 = head.r.rs2;
        case (head.r.funct3)
          F3_ADD:  alu_op = (head.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
        if (head.r.funct7 != F7_BASE &&
            !(head.r.funct7 == F7_SUB && head.r.funct3 == F3_ADD))
          legal = 1'b0;
        wr_ok = legal;
      end
      OPC_OP_IMM:
      begin
        rd  = head.i.rd;
        rs1 = head.i.rs1;
        imm = {{(XLEN-12){head.i.imm12[11]}}, head.i.imm12};
        case (head.i.funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
        wr_ok = legal;
      end
      OPC_LUI:
      begin
        rd     = head.r.rd;
        imm    = {{(XLEN-32){head[31]}}, head[31:12], 12'b0};
        alu_op = ALU_PASSB;
        wr_ok  = 1'b1;
      end
      OPC_LOAD:
      begin
        rd    = head.i.rd;
        rs1   = head.i.rs1;
        imm   = {{(XLEN-12){head.i.imm12[11]}}, head.i.imm12};
        load  = (head.i.funct3 == F3_DOUBLE);
        wr_ok = load;
      end
      OPC_STORE:
      begin
        rs1   = head.s.rs1;
        rs2   = head.s.rs2;
        imm   = {{(XLEN-12){head.s.imm_hi[6]}}, head.s.imm_hi, head.s.imm_lo};
        store = (head.s.funct3 == F3_DOUBLE);
      end
      default: ; // Illegal words retire with no effect.
    endcase
  end

  // ****************************************
  // Output register into execute.
  // ****************************************
  always_ff @(posedge i_riscv_clk or posedge i_riscv_rst)
  begin
    if (i_riscv_rst)
    begin
      o_dec_valid <= 1'b0;
      o_dec_we    <= 1'b0;
      o_dec_load  <= 1'b0;
      o_dec_store <= 1'b0;
      pc          <= RESET_PC;
    end
    else if (!i_stall)
    begin
      o_dec_valid <= issue;
      o_dec_we    <= issue && wr_ok && (rd != '0); // Writes to x0 are dropped here.
      o_dec_load  <= issue && load;
      o_dec_store <= issue && store;
      if (issue)
        pc <= pc + 64'd4;
    end
  end

  always_ff @(posedge i_riscv_clk)
  begin
    if (issue)
    begin
      o_dec_pc     <= pc;
      o_dec_inst   <= head;
      o_dec_rd     <= rd;
      o_dec_rs1    <= rs1;
      o_dec_rs2    <= rs2;
      o_dec_op_a   <= op_a;
      o_dec_op_b   <= op_b;
      o_dec_imm    <= imm;
      o_dec_alu_op <= alu_op;
    end
  end

  // A source that keeps to its credits never writes into a full queue.
  a_no_overflow: assert property (@(posedge i_riscv_clk) disable iff (i_riscv_rst)
    i_inst_valid |-> q_count != CNT_W'(INST_DEPTH));

endmodule

// File: rtl/riscv_pkg.sv
package riscv_pkg;

  // ****************************************
  // RV64 widths.
  // ****************************************
  localparam int XLEN    = 64;
  localparam int ILEN    = 32;
  localparam int RADDR_W = 5;

  // ****************************************
  // Opcodes and function codes.
  // ****************************************
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  localparam logic [2:0] F3_ADD    = 3'b000; // Also SUB and ADDI.
  localparam logic [2:0] F3_SLT    = 3'b010;
  localparam logic [2:0] F3_DOUBLE = 3'b011; // LD and SD.
  localparam logic [2:0] F3_XOR    = 3'b100;
  localparam logic [2:0] F3_OR     = 3'b110;
  localparam logic [2:0] F3_AND    = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // ALU operations, chosen in decode and carried out in execute.
  localparam logic [2:0] ALU_ADD   = 3'd0;
  localparam logic [2:0] ALU_SUB   = 3'd1;
  localparam logic [2:0] ALU_AND   = 3'd2;
  localparam logic [2:0] ALU_OR    = 3'd3;
  localparam logic [2:0] ALU_XOR   = 3'd4;
  localparam logic [2:0] ALU_SLT   = 3'd5;
  localparam logic [2:0] ALU_PASSB = 3'd6;

  // One instruction word, seen through the R, I or S layout.
  typedef union packed {
    struct packed {
      logic [6:0]         funct7;
      logic [RADDR_W-1:0] rs2;
      logic [RADDR_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [RADDR_W-1:0] rd;
      logic [6:0]         opcode;
    } r;
    struct packed {
      logic [11:0]        imm12;
      logic [RADDR_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [RADDR_W-1:0] rd;
      logic [6:0]         opcode;
    } i;
    struct packed {
      logic [6:0]         imm_hi;
      logic [RADDR_W-1:0] rs2;
      logic [RADDR_W-1:0] rs1;
      logic [2:0]         funct3;
      logic [4:0]         imm_lo;
      logic [6:0]         opcode;
    } s;
  } riscv_inst_u;

endpackage
